/* issue_pkg.sv */
/*
 Shared definitions for the issue cluster.
 Width and count constants, the opcode enum,
 the micro-op struct and the writeback struct.
 */

package issue_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Widths and counts.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int PRF_AW   = 4;
   localparam int PRF_N    = 1 << PRF_AW;
   localparam int DW       = 16;
   localparam int ROB_AW   = 4;
   localparam int RS_AW    = 2;
   localparam int RS_N     = 1 << RS_AW;
   localparam int NUM_RS   = 2;
   localparam int RS_SEL_W = $clog2(NUM_RS);
   localparam int UNIT_W   = 1;

   // In-flight limit equals the number of ROB tags.
   localparam logic [ROB_AW:0] INFLIGHT_MAX = 1 << ROB_AW;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Opcodes.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef enum logic [2:0] {
      OPC_LI   = 3'd0,
      OPC_ADD  = 3'd1,
      OPC_SUB  = 3'd2,
      OPC_AND  = 3'd3,
      OPC_XOR  = 3'd4,
      OPC_ADDI = 3'd5
   } opc_e;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Micro-op and writeback.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   typedef struct packed {
      logic [UNIT_W-1:0] unit;
      opc_e              opc;
      logic [DW-1:0]     imm;
      logic [PRF_AW-1:0] prs1;
      logic              prs1_re;
      logic [PRF_AW-1:0] prs2;
      logic              prs2_re;
      logic [PRF_AW-1:0] prd;
      logic              prd_we;
      logic [ROB_AW-1:0] rob_id;
   } uop_t;

   typedef struct packed {
      logic [ROB_AW-1:0] rob_id;
      logic [PRF_AW-1:0] prd;
      logic              prd_we;
      logic [DW-1:0]     data;
   } wb_t;

endpackage

/* dispatch_router.sv */
/*
 Dispatch router.
 ROB tag assignment, in-flight limit, busy-set request
 and unit decode into one station push.
 */

`timescale 1ns/1ns

module dispatch_router
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            disp_valid,
   input  issue_pkg::uop_t                 disp_uop,
   output logic                            disp_ready,
   output logic [issue_pkg::ROB_AW-1:0]    disp_rob_id,
   input  logic [issue_pkg::NUM_RS-1:0]    rs_full,
   output logic [issue_pkg::NUM_RS-1:0]    rs_push,
   output issue_pkg::uop_t                 push_uop,
   output logic                            busy_set_valid,
   output logic [issue_pkg::PRF_AW-1:0]    busy_set_addr,
   input  logic                            wb_done
);

   logic [issue_pkg::ROB_AW-1:0] rob_tag_q;
   logic [issue_pkg::ROB_AW:0]   inflight_q;
   logic                         accept;

   // Ready depends only on the target station and the in-flight count.
   assign disp_ready  = ~rs_full[disp_uop.unit] & (inflight_q != issue_pkg::INFLIGHT_MAX);
   assign accept      = disp_valid & disp_ready;
   assign disp_rob_id = rob_tag_q;

   // Unit field selects exactly one push line.
   always_comb
   begin
      rs_push = '0;
      rs_push[disp_uop.unit] = accept;
   end

   // Stamp the tag into the op handed to the stations.
   always_comb
   begin
      push_uop        = disp_uop;
      push_uop.rob_id = rob_tag_q;
   end

   assign busy_set_valid = accept & disp_uop.prd_we;
   assign busy_set_addr  = disp_uop.prd;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         rob_tag_q  <= '0;
         inflight_q <= '0;
      end
      else
      begin
         if (accept)
            rob_tag_q <= rob_tag_q + 1'b1;
         case ({accept, wb_done})
            2'b10:   inflight_q <= inflight_q + 1'b1;
            2'b01:   inflight_q <= inflight_q - 1'b1;
            default: inflight_q <= inflight_q;
         endcase
      end
   end

endmodule

/* issue_rs.sv */
/*
 Reservation station.
 Entry storage with free list, wakeup from the busy vector,
 lowest-index select and the output register.
 */

`timescale 1ns/1ns

module issue_rs
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           push,
   input  issue_pkg::uop_t                push_uop,
   output logic                           full,
   input  logic [issue_pkg::PRF_N-1:0]    busy,
   output logic                           ex_valid,
   output issue_pkg::uop_t                ex_uop,
   input  logic                           ex_pop
);

   issue_pkg::uop_t                ent_q [issue_pkg::RS_N];
   logic [issue_pkg::RS_N-1:0]     free_q;
   logic [issue_pkg::RS_N-1:0]     free_nxt;
   logic [issue_pkg::RS_N-1:0]     rdy_vec;
   logic [issue_pkg::RS_AW-1:0]    free_addr;
   logic [issue_pkg::RS_AW-1:0]    rdy_addr;
   logic                           has_rdy;
   logic                           sel_load;
   logic                           out_valid_q;
   issue_pkg::uop_t                out_uop_q;

   // Lowest set bit of a slot vector.
   function automatic logic [issue_pkg::RS_AW-1:0] lowest_set(
      input logic [issue_pkg::RS_N-1:0] vec
   );
      logic [issue_pkg::RS_AW-1:0] idx;
      idx = '0;
      for (int i = issue_pkg::RS_N - 1; i >= 0; i--)
      begin
         if (vec[i])
            idx = i[issue_pkg::RS_AW-1:0];
      end
      return idx;
   endfunction

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Free list.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign free_addr = lowest_set(free_q);
   assign full      = ~|free_q;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Wakeup and select.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb
   begin
      for (int i = 0; i < issue_pkg::RS_N; i++)
      begin
         rdy_vec[i] = ~free_q[i]
                      & (~ent_q[i].prs1_re | ~busy[ent_q[i].prs1])
                      & (~ent_q[i].prs2_re | ~busy[ent_q[i].prs2]);
      end
   end

   assign has_rdy  = |rdy_vec;
   assign rdy_addr = lowest_set(rdy_vec);

   // Output slot is open when empty or being drained this cycle.
   assign sel_load = has_rdy & (~out_valid_q | ex_pop);

   // Pushed slot and selected slot are never the same entry.
   always_comb
   begin
      free_nxt = free_q;
      if (push)
         free_nxt[free_addr] = 1'b0;
      if (sel_load)
         free_nxt[rdy_addr] = 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         free_q      <= '1;
         out_valid_q <= 1'b0;
      end
      else
      begin
         free_q      <= free_nxt;
         out_valid_q <= sel_load | (out_valid_q & ~ex_pop);
      end
   end

   // Payload storage.
   always_ff @(posedge clk)
   begin
      if (push)
         ent_q[free_addr] <= push_uop;
      if (sel_load)
         out_uop_q <= ent_q[rdy_addr];
   end

   assign ex_valid = out_valid_q;
   assign ex_uop   = out_uop_q;

endmodule

/* busy_table.sv */
/*
 Busy table.
 One pending bit per physical register.
 */

`timescale 1ns/1ns

module busy_table
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic                           set_valid,
   input  logic [issue_pkg::PRF_AW-1:0]   set_addr,
   input  logic                           clr_valid,
   input  logic [issue_pkg::PRF_AW-1:0]   clr_addr,
   output logic [issue_pkg::PRF_N-1:0]    busy
);

   logic [issue_pkg::PRF_N-1:0] busy_q;
   logic [issue_pkg::PRF_N-1:0] busy_nxt;

   // Clear first so that a set on the same register wins.
   always_comb
   begin
      busy_nxt = busy_q;
      if (clr_valid)
         busy_nxt[clr_addr] = 1'b0;
      if (set_valid && (set_addr != '0))
         busy_nxt[set_addr] = 1'b1;
   end

   always_ff @(posedge clk)
   begin
      if (rst)
         busy_q <= '0;
      else
         busy_q <= busy_nxt;
   end

   assign busy = busy_q;

endmodule

/* phys_regfile.sv */
/*
 Physical register file.
 Two combinational read ports and one write port.
 */

`timescale 1ns/1ns

module phys_regfile
(
   input  logic                           clk,
   input  logic                           rst,
   input  logic [issue_pkg::PRF_AW-1:0]   raddr1,
   output logic [issue_pkg::DW-1:0]       rdata1,
   input  logic [issue_pkg::PRF_AW-1:0]   raddr2,
   output logic [issue_pkg::DW-1:0]       rdata2,
   input  logic                           we,
   input  logic [issue_pkg::PRF_AW-1:0]   waddr,
   input  logic [issue_pkg::DW-1:0]       wdata
);

   logic [issue_pkg::DW-1:0] regs_q [issue_pkg::PRF_N];

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         for (int i = 0; i < issue_pkg::PRF_N; i++)
            regs_q[i] <= '0;
      end
      else if (we)
         regs_q[waddr] <= wdata;
   end

   // Reads see the old value during a same-cycle write.
   assign rdata1 = regs_q[raddr1];
   assign rdata2 = regs_q[raddr2];

endmodule

/* wb_arbiter.sv */
/*
 Writeback arbiter.
 Round-robin pop of station outputs, operand read,
 ALU evaluation and the registered writeback.
 */

`timescale 1ns/1ns

module wb_arbiter
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic [issue_pkg::NUM_RS-1:0]    ex_valid,
   input  issue_pkg::uop_t                 ex_uop [issue_pkg::NUM_RS],
   output logic [issue_pkg::NUM_RS-1:0]    ex_pop,
   output logic [issue_pkg::PRF_AW-1:0]    raddr1,
   output logic [issue_pkg::PRF_AW-1:0]    raddr2,
   input  logic [issue_pkg::DW-1:0]        rdata1,
   input  logic [issue_pkg::DW-1:0]        rdata2,
   output logic                            wb_valid,
   output issue_pkg::wb_t                  wb
);

   logic [issue_pkg::RS_SEL_W-1:0] last_q;
   logic [issue_pkg::RS_SEL_W-1:0] sel;
   logic                           any_valid;
   issue_pkg::uop_t                cur_uop;
   logic [issue_pkg::DW-1:0]       alu_res;
   logic                           wb_valid_q;
   issue_pkg::wb_t                 wb_q;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Round-robin pick.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign any_valid = |ex_valid;

   // Search begins one past the station popped last.
   always_comb
   begin : pick_blk
      int   idx;
      logic found;
      sel   = last_q;
      found = 1'b0;
      for (int k = 1; k <= issue_pkg::NUM_RS; k++)
      begin
         idx = (int'(last_q) + k) % issue_pkg::NUM_RS;
         if (!found && ex_valid[idx])
         begin
            sel   = idx[issue_pkg::RS_SEL_W-1:0];
            found = 1'b1;
         end
      end
   end

   always_comb
   begin
      ex_pop = '0;
      ex_pop[sel] = any_valid;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Operands and ALU.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign cur_uop = ex_uop[sel];
   assign raddr1  = cur_uop.prs1;
   assign raddr2  = cur_uop.prs2;

   always_comb
   begin
      case (cur_uop.opc)
         issue_pkg::OPC_LI:   alu_res = cur_uop.imm;
         issue_pkg::OPC_ADD:  alu_res = rdata1 + rdata2;
         issue_pkg::OPC_SUB:  alu_res = rdata1 - rdata2;
         issue_pkg::OPC_AND:  alu_res = rdata1 & rdata2;
         issue_pkg::OPC_XOR:  alu_res = rdata1 ^ rdata2;
         issue_pkg::OPC_ADDI: alu_res = rdata1 + cur_uop.imm;
         default:             alu_res = '0;
      endcase
   end

   // Reset pointer so that station 0 is searched first.
   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         wb_valid_q <= 1'b0;
         last_q     <= '1;
      end
      else
      begin
         wb_valid_q <= any_valid;
         if (any_valid)
            last_q <= sel;
      end
   end

   always_ff @(posedge clk)
   begin
      if (any_valid)
      begin
         wb_q.rob_id <= cur_uop.rob_id;
         wb_q.prd    <= cur_uop.prd;
         wb_q.prd_we <= cur_uop.prd_we;
         wb_q.data   <= alu_res;
      end
   end

   assign wb_valid = wb_valid_q;
   assign wb       = wb_q;

endmodule

/* issue_cluster.sv */
/*
 Issue cluster top level.
 Router, station array, busy table, register file and arbiter.
 */

`timescale 1ns/1ns

module issue_cluster
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            disp_valid,
   input  issue_pkg::uop_t                 disp_uop,
   output logic                            disp_ready,
   output logic [issue_pkg::ROB_AW-1:0]    disp_rob_id,
   output logic                            wb_valid,
   output issue_pkg::wb_t                  wb
);

   logic [issue_pkg::NUM_RS-1:0]   rs_full;
   logic [issue_pkg::NUM_RS-1:0]   rs_push;
   issue_pkg::uop_t                push_uop;
   logic [issue_pkg::NUM_RS-1:0]   ex_valid;
   issue_pkg::uop_t                ex_uop [issue_pkg::NUM_RS];
   logic [issue_pkg::NUM_RS-1:0]   ex_pop;
   logic                           busy_set_valid;
   logic [issue_pkg::PRF_AW-1:0]   busy_set_addr;
   logic [issue_pkg::PRF_N-1:0]    busy;
   logic [issue_pkg::PRF_AW-1:0]   raddr1;
   logic [issue_pkg::PRF_AW-1:0]   raddr2;
   logic [issue_pkg::DW-1:0]       rdata1;
   logic [issue_pkg::DW-1:0]       rdata2;
   logic                           wb_commit;

   // Writeback with a destination updates state.
   assign wb_commit = wb_valid & wb.prd_we;

   dispatch_router u_router (
      .clk            (clk),
      .rst            (rst),
      .disp_valid     (disp_valid),
      .disp_uop       (disp_uop),
      .disp_ready     (disp_ready),
      .disp_rob_id    (disp_rob_id),
      .rs_full        (rs_full),
      .rs_push        (rs_push),
      .push_uop       (push_uop),
      .busy_set_valid (busy_set_valid),
      .busy_set_addr  (busy_set_addr),
      .wb_done        (wb_valid)
   );

   for (genvar g = 0; g < issue_pkg::NUM_RS; g++)
   begin : g_rs
      issue_rs u_rs (
         .clk      (clk),
         .rst      (rst),
         .push     (rs_push[g]),
         .push_uop (push_uop),
         .full     (rs_full[g]),
         .busy     (busy),
         .ex_valid (ex_valid[g]),
         .ex_uop   (ex_uop[g]),
         .ex_pop   (ex_pop[g])
      );
   end

   busy_table u_busy (
      .clk       (clk),
      .rst       (rst),
      .set_valid (busy_set_valid),
      .set_addr  (busy_set_addr),
      .clr_valid (wb_commit),
      .clr_addr  (wb.prd),
      .busy      (busy)
   );

   phys_regfile u_prf (
      .clk    (clk),
      .rst    (rst),
      .raddr1 (raddr1),
      .rdata1 (rdata1),
      .raddr2 (raddr2),
      .rdata2 (rdata2),
      .we     (wb_commit),
      .waddr  (wb.prd),
      .wdata  (wb.data)
   );

   wb_arbiter u_arb (
      .clk      (clk),
      .rst      (rst),
      .ex_valid (ex_valid),
      .ex_uop   (ex_uop),
      .ex_pop   (ex_pop),
      .raddr1   (raddr1),
      .raddr2   (raddr2),
      .rdata1   (rdata1),
      .rdata2   (rdata2),
      .wb_valid (wb_valid),
      .wb       (wb)
   );

endmodule

/* issue_cluster_properties.sv */
/*
 Concurrent assertions for the issue cluster.
 Pop exclusivity, quiet writeback around reset
 and dispatch back-pressure from a full station.
 */

`timescale 1ns/1ns

module issue_cluster_properties
(
   input logic                            clk,
   input logic                            rst,
   input issue_pkg::uop_t                 disp_uop,
   input logic                            disp_ready,
   input logic [issue_pkg::NUM_RS-1:0]    rs_full,
   input logic [issue_pkg::NUM_RS-1:0]    ex_pop,
   input logic                            wb_valid
);

   int unsigned fail_count = 0;

   pop_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(ex_pop))
   else
   begin
      fail_count++;
      $error("More than one station popped in one cycle.");
   end

   // Quiet for the reset cycles and the first cycle out of reset.
   wb_quiet_rst: assert property (@(posedge clk) rst |=> !wb_valid)
   else
   begin
      fail_count++;
      $error("wb_valid high right after a reset cycle.");
   end

   full_blocks: assert property (@(posedge clk) disable iff (rst)
                                 rs_full[disp_uop.unit] |-> !disp_ready)
   else
   begin
      fail_count++;
      $error("disp_ready high while the target station is full.");
   end

endmodule

bind issue_cluster issue_cluster_properties u_props (
   .clk        (clk),
   .rst        (rst),
   .disp_uop   (disp_uop),
   .disp_ready (disp_ready),
   .rs_full    (rs_full),
   .ex_pop     (ex_pop),
   .wb_valid   (wb_valid)
);

/* issue_cluster_tb.sv */
/*
 Testbench for the issue cluster.
 Clock and reset, a table of micro-ops applied with random idle gaps,
 an in-order reference model and a writeback monitor.
 */

`timescale 1ns/1ns

module issue_cluster_tb;

   localparam int HALF_PERIOD    = 20;
   localparam int SETTLE         = 10;
   localparam int ACCEPT_TIMEOUT = 200;
   localparam int DRAIN_TIMEOUT  = 500;
   localparam int TAG_N          = 1 << issue_pkg::ROB_AW;

   // One table row: the op plus its scheduling flags.
   typedef struct packed {
      issue_pkg::uop_t uop;
      logic            drain;
      logic            burst;
   } row_t;

   logic                          clk;
   logic                          rst;
   logic                          disp_valid;
   issue_pkg::uop_t               disp_uop;
   logic                          disp_ready;
   logic [issue_pkg::ROB_AW-1:0]  disp_rob_id;
   logic                          wb_valid;
   issue_pkg::wb_t                wb;

   row_t                          table_q [$];
   logic [issue_pkg::DW-1:0]      ref_regs [issue_pkg::PRF_N];
   issue_pkg::wb_t                exp_wb [TAG_N];
   logic [TAG_N-1:0]              exp_pend;
   logic [31:0]                   lcg_state;
   int                            errors;
   int                            accepted;
   int                            wb_count;
   int                            stalls;
   logic                          timed_out;

   issue_cluster uut (
      .clk         (clk),
      .rst         (rst),
      .disp_valid  (disp_valid),
      .disp_uop    (disp_uop),
      .disp_ready  (disp_ready),
      .disp_rob_id (disp_rob_id),
      .wb_valid    (wb_valid),
      .wb          (wb)
   );

   initial
   begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Helpers.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Result of one op from the opcode definitions.
   function automatic logic [issue_pkg::DW-1:0] expected_result(
      input issue_pkg::opc_e           opc,
      input logic [issue_pkg::DW-1:0]  a,
      input logic [issue_pkg::DW-1:0]  b,
      input logic [issue_pkg::DW-1:0]  imm
   );
      case (opc)
         issue_pkg::OPC_LI:   return imm;
         issue_pkg::OPC_ADD:  return a + b;
         issue_pkg::OPC_SUB:  return a - b;
         issue_pkg::OPC_AND:  return a & b;
         issue_pkg::OPC_XOR:  return a ^ b;
         issue_pkg::OPC_ADDI: return a + imm;
         default:             return '0;
      endcase
   endfunction

   task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
      if (got !== exp)
      begin
         errors++;
         $display("ERROR %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      end
   endtask

   // Source enables follow from the opcode.
   task automatic add_op(
      input logic                        unit,
      input issue_pkg::opc_e             opc,
      input logic [issue_pkg::DW-1:0]    imm,
      input logic [issue_pkg::PRF_AW-1:0] rs1,
      input logic [issue_pkg::PRF_AW-1:0] rs2,
      input logic [issue_pkg::PRF_AW-1:0] rd,
      input logic                        drain,
      input logic                        burst
   );
      row_t r;
      r             = '0;
      r.uop.unit    = unit;
      r.uop.opc     = opc;
      r.uop.imm     = imm;
      r.uop.prs1    = rs1;
      r.uop.prs1_re = (opc != issue_pkg::OPC_LI);
      r.uop.prs2    = rs2;
      r.uop.prs2_re = (opc != issue_pkg::OPC_LI) && (opc != issue_pkg::OPC_ADDI);
      r.uop.prd     = rd;
      r.uop.prd_we  = 1'b1;
      r.drain       = drain;
      r.burst       = burst;
      table_q.push_back(r);
   endtask

   task automatic build_table();
      // unit, opcode, imm, rs1, rs2, rd, drain first, no idle gap.
      add_op(1'b0, issue_pkg::OPC_LI,   16'h1234, 4'd0,  4'd0,  4'd1,  1'b0, 1'b0);
      add_op(1'b1, issue_pkg::OPC_LI,   16'h00ff, 4'd0,  4'd0,  4'd2,  1'b0, 1'b0);
      add_op(1'b0, issue_pkg::OPC_LI,   16'h0f0f, 4'd0,  4'd0,  4'd3,  1'b0, 1'b0);
      add_op(1'b1, issue_pkg::OPC_LI,   16'h8001, 4'd0,  4'd0,  4'd4,  1'b0, 1'b0);
      // Chain in station 0 with independent ops in station 1.
      add_op(1'b0, issue_pkg::OPC_ADD,  16'h0000, 4'd1,  4'd2,  4'd5,  1'b1, 1'b0);
      add_op(1'b1, issue_pkg::OPC_LI,   16'h0042, 4'd0,  4'd0,  4'd6,  1'b0, 1'b0);
      add_op(1'b0, issue_pkg::OPC_SUB,  16'h0000, 4'd5,  4'd3,  4'd7,  1'b0, 1'b0);
      add_op(1'b0, issue_pkg::OPC_ADDI, 16'h0010, 4'd7,  4'd0,  4'd8,  1'b0, 1'b0);
      add_op(1'b1, issue_pkg::OPC_XOR,  16'h0000, 4'd4,  4'd2,  4'd9,  1'b0, 1'b0);
      add_op(1'b0, issue_pkg::OPC_AND,  16'h0000, 4'd8,  4'd1,  4'd10, 1'b0, 1'b0);
      add_op(1'b0, issue_pkg::OPC_XOR,  16'h0000, 4'd10, 4'd9,  4'd11, 1'b0, 1'b0);
      // Dependencies across both stations.
      add_op(1'b1, issue_pkg::OPC_ADD,  16'h0000, 4'd11, 4'd6,  4'd12, 1'b1, 1'b0);
      add_op(1'b0, issue_pkg::OPC_SUB,  16'h0000, 4'd1,  4'd4,  4'd13, 1'b0, 1'b0);
      add_op(1'b1, issue_pkg::OPC_AND,  16'h0000, 4'd12, 4'd13, 4'd14, 1'b0, 1'b0);
      add_op(1'b0, issue_pkg::OPC_ADDI, 16'hfff0, 4'd14, 4'd0,  4'd15, 1'b0, 1'b0);
      // Slow chain in station 1, then five waiting ops to fill station 0.
      add_op(1'b1, issue_pkg::OPC_ADDI, 16'h0001, 4'd15, 4'd0,  4'd1,  1'b1, 1'b1);
      add_op(1'b1, issue_pkg::OPC_ADDI, 16'h0002, 4'd1,  4'd0,  4'd2,  1'b0, 1'b1);
      add_op(1'b1, issue_pkg::OPC_ADD,  16'h0000, 4'd2,  4'd1,  4'd3,  1'b0, 1'b1);
      add_op(1'b1, issue_pkg::OPC_XOR,  16'h0000, 4'd3,  4'd15, 4'd4,  1'b0, 1'b1);
      add_op(1'b0, issue_pkg::OPC_ADDI, 16'h0003, 4'd4,  4'd0,  4'd5,  1'b0, 1'b1);
      add_op(1'b0, issue_pkg::OPC_ADD,  16'h0000, 4'd4,  4'd4,  4'd6,  1'b0, 1'b1);
      add_op(1'b0, issue_pkg::OPC_SUB,  16'h0000, 4'd4,  4'd13, 4'd7,  1'b0, 1'b1);
      add_op(1'b0, issue_pkg::OPC_AND,  16'h0000, 4'd4,  4'd12, 4'd8,  1'b0, 1'b1);
      add_op(1'b0, issue_pkg::OPC_XOR,  16'h0000, 4'd4,  4'd9,  4'd10, 1'b0, 1'b1);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Dispatch and reference model.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic record_accept(input issue_pkg::uop_t u);
      logic [issue_pkg::DW-1:0]     res;
      logic [issue_pkg::ROB_AW-1:0] tag;
      tag = disp_rob_id;
      compare(tag, accepted % TAG_N, "ROB tag in dispatch order");
      compare(exp_pend[tag], 1'b0, "ROB tag free at dispatch");
      res = expected_result(u.opc, ref_regs[u.prs1], ref_regs[u.prs2], u.imm);
      if (u.prd_we)
         ref_regs[u.prd] = res;
      exp_wb[tag].rob_id = tag;
      exp_wb[tag].prd    = u.prd;
      exp_wb[tag].prd_we = u.prd_we;
      exp_wb[tag].data   = res;
      exp_pend[tag]      = 1'b1;
      accepted++;
   endtask

   // Called on a falling edge; returns on a falling edge.
   task automatic dispatch_row(input int idx, input row_t r);
      int   waited;
      logic done;
      waited     = 0;
      done       = 1'b0;
      disp_uop   = r.uop;
      disp_valid = 1'b1;
      while (!done && waited < ACCEPT_TIMEOUT)
      begin
         #SETTLE;
         if (disp_ready)
         begin
            record_accept(r.uop);
            done = 1'b1;
         end
         else
            stalls++;
         @(negedge clk);
         waited++;
      end
      disp_valid = 1'b0;
      if (!done)
      begin
         $display("Timeout: op %0d was never accepted by the DUT", idx);
         timed_out = 1'b1;
      end
   endtask

   task automatic wait_drain(input string what);
      int waited;
      waited = 0;
      #SETTLE;
      while (wb_count != accepted && waited < DRAIN_TIMEOUT)
      begin
         #(2 * HALF_PERIOD);
         waited++;
      end
      if (wb_count != accepted)
      begin
         $display("Timeout: writebacks still outstanding %s", what);
         timed_out = 1'b1;
      end
      @(negedge clk);
   endtask

   // Writeback monitor, sampled mid-cycle.
   always @(negedge clk)
   begin
      if (!rst && wb_valid)
      begin
         compare(exp_pend[wb.rob_id], 1'b1, $sformatf("writeback tag %0d pending", wb.rob_id));
         compare(wb.prd, exp_wb[wb.rob_id].prd, $sformatf("tag %0d prd", wb.rob_id));
         compare(wb.prd_we, exp_wb[wb.rob_id].prd_we, $sformatf("tag %0d prd_we", wb.rob_id));
         compare(wb.data, exp_wb[wb.rob_id].data, $sformatf("tag %0d data", wb.rob_id));
         exp_pend[wb.rob_id] = 1'b0;
         wb_count++;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Main sequence.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   initial
   begin
      errors     = 0;
      accepted   = 0;
      wb_count   = 0;
      stalls     = 0;
      timed_out  = 1'b0;
      exp_pend   = '0;
      lcg_state  = 32'h545de27e;
      rst        = 1'b1;
      disp_valid = 1'b0;
      disp_uop   = '0;
      for (int i = 0; i < issue_pkg::PRF_N; i++)
         ref_regs[i] = '0;
      build_table();

      repeat (4) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      #SETTLE;
      compare(disp_ready, 1'b1, "disp_ready after reset");
      compare(wb_valid, 1'b0, "wb_valid after reset");
      @(negedge clk);

      foreach (table_q[i])
      begin
         if (!timed_out && table_q[i].drain)
            wait_drain($sformatf("before op %0d", i));
         if (!timed_out && !table_q[i].burst)
         begin
            lcg_state = lcg_next(lcg_state);
            repeat (int'(lcg_state[31:30])) @(negedge clk);
         end
         if (!timed_out)
            dispatch_row(i, table_q[i]);
      end

      if (!timed_out)
         wait_drain("at end of table");
      // Extra cycles expose any stray writeback.
      repeat (4) @(negedge clk);
      if (!timed_out)
      begin
         compare(accepted, table_q.size(), "ops accepted");
         compare(wb_count, accepted, "writeback count");
         compare(stalls != 0, 1'b1, "disp_ready dropped under back-pressure");
      end

      $display("Checks done: %0d errors, %0d assertion failures, %0d timeouts",
               errors, uut.u_props.fail_count, timed_out);
      if (errors == 0 && !timed_out && uut.u_props.fail_count == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule

/* build.f */
issue_pkg.sv
dispatch_router.sv
issue_rs.sv
busy_table.sv
phys_regfile.sv
wb_arbiter.sv
issue_cluster.sv
issue_cluster_properties.sv
issue_cluster_tb.sv

/* run.sh */
#!/bin/sh
# Compile and run the issue cluster testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
   --top-module issue_cluster_tb -o issue_sim
if [ $? -ne 0 ]; then
   echo "Verilator compile failed"
   exit 1
fi

out=$(./obj_dir/issue_sim 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   echo "Simulation run returned a failing status"
   exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
   exit 0
fi
exit 1
